// ==== filelist.f ====
+incdir+include
src/revo_sample_pkg.sv
src/revo_link_pkg.sv
src/revo_window_detector.sv
src/revo_event_fifo.sv
src/revo_trigger_encoder.sv
src/revo_encoder_top.sv
testbench/revo_encoder_tb.sv

// ==== Bender.yml ====
package:
  name: revo_encoder

sources:
  # packages first, then the design
  - files:
      - src/revo_sample_pkg.sv
      - src/revo_link_pkg.sv
      - src/revo_window_detector.sv
      - src/revo_event_fifo.sv
      - src/revo_trigger_encoder.sv
      - src/revo_encoder_top.sv

  # testbench with its check header
  - target: test
    include_dirs:
      - include
    files:
      - testbench/revo_encoder_tb.sv

// ==== include/revo_tb_checks.svh ====
`ifndef REVO_TB_CHECKS_SVH
`define REVO_TB_CHECKS_SVH

// first mismatch ends the run
task automatic fail_and_stop(input string message);
	$display("ERROR: %s", message);
	$display("STATUS: FAIL");
	$fatal(1, "%s", message);
endtask

task automatic check_link_word(input string name, input link_word_t got,
		input link_word_t expected);
	if (got !== expected) begin
		fail_and_stop($sformatf("%s got %h expected %h", name, got, expected));
	end
endtask

task automatic check_frame_number(input string name, input frame_number_t got,
		input frame_number_t expected);
	if (got !== expected) begin
		fail_and_stop($sformatf("%s got %h expected %h", name, got, expected));
	end
endtask

task automatic check_trigger_count(input string name, input trigger_count_t got,
		input trigger_count_t expected);
	if (got !== expected) begin
		fail_and_stop($sformatf("%s got %h expected %h", name, got, expected));
	end
endtask

task automatic check_flag(input string name, input logic got, input logic expected);
	if (got !== expected) begin
		fail_and_stop($sformatf("%s got %h expected %h", name, got, expected));
	end
endtask

// xorshift32 step for random sample words
function automatic logic [31:0] xorshift32(input logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

// ==== testbench/revo_encoder_tb.sv ====
`timescale 1ns/1ps

module revo_encoder_tb
	import revo_sample_pkg::*;
	import revo_link_pkg::*;
();

	// frames over all tests for the run limit
	localparam int TOTAL_FRAMES = 131;
	localparam int CYCLE_LIMIT = 2 * TOTAL_FRAMES * CYCLES_PER_FRAME + 64;

	logic           clock127;
	logic           reset;
	sample_word_t   sample_word;
	logic           encoded_clock_enable;
	link_word_t     link_word;
	frame_number_t  revo_frame;
	trigger_count_t trigger_count;
	logic           overflow;

	// reference model state
	encoder_state_t model_state;
	frame_number_t  model_queue[$];
	link_word_t     exp_link;
	logic           exp_enable;
	frame_number_t  exp_revo;
	trigger_count_t exp_count;
	logic           exp_overflow;
	logic           pending;
	frame_number_t  pending_frame;
	frame_number_t  frame_index;
	logic [31:0]    rng;
	int             cycle_count;

	`include "revo_tb_checks.svh"

	revo_encoder_top revo_encoder_top_inst (
		.clock127             (clock127),
		.reset                (reset),
		.sample_word          (sample_word),
		.encoded_clock_enable (encoded_clock_enable),
		.link_word            (link_word),
		.revo_frame           (revo_frame),
		.trigger_count        (trigger_count),
		.overflow             (overflow)
	);

	initial begin
		clock127 = 1'b0;
		forever #20 clock127 = ~clock127;
	end

	always @(posedge clock127) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			fail_and_stop("simulation ran past its cycle limit without finishing");
		end
	end

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// walk the window from earliest sample to latest
	function automatic logic marker_detected(input sample_window_t bits);
		logic early_seen;
		logic late_seen;
		early_seen = 1'b0;
		late_seen = 1'b0;
		for (int i = 0; i < WINDOW_WIDTH; i++) begin
			if (bits[WINDOW_WIDTH-1-i]) begin
				if (i < GUARD_HALF) early_seen = 1'b1;
				else late_seen = 1'b1;
			end
		end
		return !early_seen && late_seen;
	endfunction

	// pop decision at the frame boundary comes before the write of last frame's event
	task automatic step_model();
		logic was_full;
		was_full = (model_queue.size() >= EVENT_FIFO_DEPTH);
		if (model_state != encoder_trigger_frame && model_queue.size() > 0) begin
			exp_revo = model_queue.pop_front();
			exp_count = exp_count + 1'b1;
			model_state = encoder_trigger_frame;
			exp_link = LINK_WORD_TRIGGER;
			exp_enable = 1'b0;
		end else begin
			exp_link = LINK_WORD_NULL;
			exp_enable = 1'b1;
			if (model_state == encoder_trigger_frame) model_state = encoder_guard_frame;
			else model_state = encoder_idle;
		end
		if (pending) begin
			if (was_full) exp_overflow = 1'b1;
			else model_queue.push_back(pending_frame);
		end
		pending = 1'b0;
	endtask

	task automatic check_outputs();
		check_link_word("link_word", link_word, exp_link);
		check_flag("encoded_clock_enable", encoded_clock_enable, exp_enable);
		check_frame_number("revo_frame", revo_frame, exp_revo);
		check_trigger_count("trigger_count", trigger_count, exp_count);
		check_flag("overflow", overflow, exp_overflow);
	endtask

	// drives one frame starting and ending on a falling edge
	task automatic run_frame(input sample_window_t bits);
		step_model();
		for (int p = 0; p < CYCLES_PER_FRAME; p++) begin
			sample_word = bits[WINDOW_WIDTH-1-SAMPLES_PER_CYCLE*p -: SAMPLES_PER_CYCLE];
			if (p == CYCLES_PER_FRAME - 1) check_outputs();
			@(negedge clock127);
		end
		pending = marker_detected(bits);
		pending_frame = frame_index;
		frame_index = frame_index + 1'b1;
	endtask

	task automatic run_quiet(input int frames);
		for (int i = 0; i < frames; i++) begin
			run_frame(16'h0000);
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------

	task automatic test_reset_state();
		run_quiet(6);
		check_trigger_count("trigger_count", trigger_count, 16'h0000);
		check_link_word("link_word", link_word, LINK_WORD_NULL);
	endtask

	task automatic test_single_marker();
		frame_number_t  marker_frame;
		trigger_count_t count_before;
		marker_frame = frame_index;
		count_before = exp_count;
		run_frame(16'h003f);
		run_quiet(2);
		// still inside the trigger frame two frames later
		check_link_word("link_word", link_word, LINK_WORD_TRIGGER);
		check_flag("encoded_clock_enable", encoded_clock_enable, 1'b0);
		check_frame_number("revo_frame", revo_frame, marker_frame);
		check_trigger_count("trigger_count", trigger_count, count_before + 1'b1);
		run_quiet(2);
	endtask

	task automatic test_rejection();
		// rise in the early half
		run_frame(16'h0fff);
		// level held high across frames
		run_frame(16'hffff);
		run_frame(16'hffff);
		run_frame(16'hffff);
		run_quiet(1);
		run_frame(16'hf000);
		run_quiet(2);
	endtask

	task automatic test_paced_markers();
		for (int i = 0; i < 6; i++) begin
			run_frame(16'h000f << (i % 2));
			run_quiet(1);
		end
		run_quiet(4);
		check_flag("overflow", overflow, 1'b0);
	endtask

	task automatic test_burst_overflow();
		for (int i = 0; i < 8; i++) begin
			run_frame(16'h00ff);
		end
		run_quiet(14);
		check_flag("overflow", overflow, 1'b1);
	endtask

	task automatic test_random_streams();
		sample_window_t bits;
		for (int i = 0; i < 64; i++) begin
			rng = xorshift32(rng);
			bits = rng[15:0];
			// about half the frames get a quiet early half
			if (rng[31]) bits[15:8] = 8'h00;
			run_frame(bits);
		end
		run_quiet(10);
	endtask

	initial begin
		reset = 1'b1;
		sample_word = '0;
		cycle_count = 0;
		model_state = encoder_idle;
		exp_link = LINK_WORD_NULL;
		exp_enable = 1'b1;
		exp_revo = '0;
		exp_count = '0;
		exp_overflow = 1'b0;
		pending = 1'b0;
		pending_frame = '0;
		frame_index = '0;
		rng = 32'h95f4_4917;
		repeat (3) @(posedge clock127);
		@(negedge clock127);
		reset = 1'b0;
		test_reset_state();
		test_single_marker();
		test_rejection();
		test_paced_markers();
		test_burst_overflow();
		test_random_streams();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== src/revo_encoder_top.sv ====
`timescale 1ns/1ps

module revo_encoder_top
	import revo_sample_pkg::*;
	import revo_link_pkg::*;
(
	input  logic           clock127,
	input  logic           reset,
	input  sample_word_t   sample_word,
	output logic           encoded_clock_enable,
	output link_word_t     link_word,
	output frame_number_t  revo_frame,
	output trigger_count_t trigger_count,
	output logic           overflow
);

	logic        event_strobe;
	revo_event_t detected_event;
	logic        frame_start;
	revo_event_t head;
	logic        not_empty;
	logic        pop;

	// ------------------------------------------------------------
	// detector
	// ------------------------------------------------------------

	revo_window_detector revo_window_detector_inst (
		.clock127       (clock127),
		.reset          (reset),
		.sample_word    (sample_word),
		.event_strobe   (event_strobe),
		.detected_event (detected_event),
		.frame_start    (frame_start)
	);

	// ------------------------------------------------------------
	// event queue
	// ------------------------------------------------------------

	revo_event_fifo revo_event_fifo_inst (
		.clock127    (clock127),
		.reset       (reset),
		.write       (event_strobe),
		.write_event (detected_event),
		.pop         (pop),
		.head        (head),
		.not_empty   (not_empty),
		.overflow    (overflow)
	);

	// ------------------------------------------------------------
	// link encoder
	// ------------------------------------------------------------

	revo_trigger_encoder revo_trigger_encoder_inst (
		.clock127             (clock127),
		.reset                (reset),
		.frame_start          (frame_start),
		.head                 (head),
		.not_empty            (not_empty),
		.pop                  (pop),
		.encoded_clock_enable (encoded_clock_enable),
		.link_word            (link_word),
		.revo_frame           (revo_frame),
		.trigger_count        (trigger_count)
	);

endmodule

// ==== src/revo_trigger_encoder.sv ====
`timescale 1ns/1ps

module revo_trigger_encoder
	import revo_link_pkg::*;
(
	input  logic           clock127,
	input  logic           reset,
	input  logic           frame_start,
	input  revo_event_t    head,
	input  logic           not_empty,
	output logic           pop,
	output logic           encoded_clock_enable,
	output link_word_t     link_word,
	output frame_number_t  revo_frame,
	output trigger_count_t trigger_count
);

	encoder_state_t state;
	logic           ready;

	// ------------------------------------------------------------
	// pop decision
	// ------------------------------------------------------------

	// a trigger frame always gets its guard frame first
	assign ready = (state != encoder_trigger_frame);

	// only at a frame boundary, so each link frame is one whole frame
	assign pop = frame_start && ready && not_empty;

	// ------------------------------------------------------------
	// frame sequencer
	// ------------------------------------------------------------

	always_ff @(posedge clock127) begin
		if (reset) begin
			state <= encoder_idle;
		end else if (frame_start) begin
			if (pop) begin
				state <= encoder_trigger_frame;
			end else begin
				unique case (state)
					encoder_trigger_frame: state <= encoder_guard_frame;
					encoder_guard_frame: state <= encoder_idle;
					default: state <= encoder_idle;
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// link outputs
	// ------------------------------------------------------------

	// forwarded clock edges are held back for the whole trigger frame
	always_ff @(posedge clock127) begin
		if (reset) begin
			link_word <= LINK_WORD_NULL;
			encoded_clock_enable <= 1'b1;
		end else if (frame_start) begin
			if (pop) begin
				link_word <= LINK_WORD_TRIGGER;
				encoded_clock_enable <= 1'b0;
			end else begin
				link_word <= LINK_WORD_NULL;
				encoded_clock_enable <= 1'b1;
			end
		end
	end

	// frame number of the event on the link, and the running total
	always_ff @(posedge clock127) begin
		if (reset) begin
			revo_frame <= '0;
			trigger_count <= '0;
		end else if (pop) begin
			revo_frame <= head.frame_number;
			trigger_count <= trigger_count + 1'b1;
		end
	end

endmodule

// ==== src/revo_event_fifo.sv ====
`timescale 1ns/1ps

module revo_event_fifo
	import revo_link_pkg::*;
(
	input  logic        clock127,
	input  logic        reset,
	input  logic        write,
	input  revo_event_t write_event,
	input  logic        pop,
	output revo_event_t head,
	output logic        not_empty,
	output logic        overflow
);

	revo_event_t storage [EVENT_FIFO_DEPTH];
	fifo_ptr_t   read_ptr;
	fifo_ptr_t   write_ptr;
	fifo_count_t count;
	logic        full;
	logic        write_accept;
	logic        pop_accept;

	// occupancy at the start of the cycle decides, a pop does not make room
	assign full = (count == FIFO_FULL_COUNT);
	assign write_accept = write && !full;
	assign pop_accept = pop && not_empty;

	assign not_empty = (count != '0);
	assign head = storage[read_ptr];

	// ------------------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------------------

	always_ff @(posedge clock127) begin
		if (reset) begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end else begin
			if (write_accept) begin
				if (write_ptr == FIFO_LAST_SLOT) begin
					write_ptr <= '0;
				end else begin
					write_ptr <= write_ptr + 1'b1;
				end
			end
			if (pop_accept) begin
				if (read_ptr == FIFO_LAST_SLOT) begin
					read_ptr <= '0;
				end else begin
					read_ptr <= read_ptr + 1'b1;
				end
			end
			// both at once leaves the count alone
			case ({write_accept, pop_accept})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	always_ff @(posedge clock127) begin
		if (write_accept) begin
			storage[write_ptr] <= write_event;
		end
	end

	// sticky until reset
	always_ff @(posedge clock127) begin
		if (reset) begin
			overflow <= 1'b0;
		end else if (write && full) begin
			overflow <= 1'b1;
		end
	end

endmodule

// ==== src/revo_window_detector.sv ====
`timescale 1ns/1ps

module revo_window_detector
	import revo_sample_pkg::*;
	import revo_link_pkg::*;
(
	input  logic         clock127,
	input  logic         reset,
	input  sample_word_t sample_word,
	output logic         event_strobe,
	output revo_event_t  detected_event,
	output logic         frame_start
);

	sample_window_t window;
	sample_window_t window_next;
	frame_phase_t   phase;
	frame_number_t  frame_number;
	logic           last_phase;
	logic           early_quiet;
	logic           late_active;

	// ------------------------------------------------------------
	// window assembly
	// ------------------------------------------------------------

	// newest word enters at the bottom, so phase 0 lands in the top nibble
	assign window_next = {window[WINDOW_WIDTH-SAMPLES_PER_CYCLE-1:0], sample_word};

	assign last_phase = (phase == LAST_PHASE);

	// quiet first half, something in the second half
	assign early_quiet = ~|window_next[WINDOW_WIDTH-1 -: GUARD_HALF];
	assign late_active = |window_next[WINDOW_WIDTH-GUARD_HALF-1:0];

	always_ff @(posedge clock127) begin
		if (reset) begin
			window <= '0;
		end else begin
			window <= window_next;
		end
	end

	// ------------------------------------------------------------
	// frame phase and frame number
	// ------------------------------------------------------------

	always_ff @(posedge clock127) begin
		if (reset) begin
			phase <= FIRST_PHASE;
			frame_number <= '0;
		end else begin
			if (last_phase) begin
				phase <= FIRST_PHASE;
				frame_number <= frame_number + 1'b1;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// decision registers
	// ------------------------------------------------------------

	// frame_start comes out of reset high since the first cycle is phase 0
	always_ff @(posedge clock127) begin
		if (reset) begin
			event_strobe <= 1'b0;
			frame_start <= 1'b1;
		end else begin
			event_strobe <= last_phase && early_quiet && late_active;
			frame_start <= last_phase;
		end
	end

	// number of the frame just completed, valid with event_strobe
	always_ff @(posedge clock127) begin
		if (last_phase) begin
			detected_event.frame_number <= frame_number;
		end
	end

endmodule

// ==== src/revo_link_pkg.sv ====
package revo_link_pkg;

	// ------------------------------------------------------------
	// frame numbering and link patterns
	// ------------------------------------------------------------

	// frames since reset, wraps
	typedef logic [15:0] frame_number_t;

	// one serializer word
	typedef logic [7:0] link_word_t;

	localparam link_word_t LINK_WORD_NULL = 8'b1100_0000;
	localparam link_word_t LINK_WORD_TRIGGER = 8'b0011_1111;

	// encoded triggers since reset
	typedef logic [15:0] trigger_count_t;

	// ------------------------------------------------------------
	// event queue
	// ------------------------------------------------------------

	typedef struct packed {
		frame_number_t frame_number;
	} revo_event_t;

	localparam int EVENT_FIFO_DEPTH = 4;
	localparam int EVENT_FIFO_PTR_WIDTH = $clog2(EVENT_FIFO_DEPTH);
	localparam int EVENT_FIFO_COUNT_WIDTH = $clog2(EVENT_FIFO_DEPTH + 1);

	typedef logic [EVENT_FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
	typedef logic [EVENT_FIFO_COUNT_WIDTH-1:0] fifo_count_t;

	localparam fifo_ptr_t FIFO_LAST_SLOT = fifo_ptr_t'(EVENT_FIFO_DEPTH - 1);
	localparam fifo_count_t FIFO_FULL_COUNT = fifo_count_t'(EVENT_FIFO_DEPTH);

	// ------------------------------------------------------------
	// encoder FSM
	// ------------------------------------------------------------

	// state names the frame currently on the link
	typedef enum logic [1:0] {
		encoder_idle,
		encoder_trigger_frame,
		encoder_guard_frame
	} encoder_state_t;

endpackage

// ==== src/revo_sample_pkg.sv ====
package revo_sample_pkg;

	// ------------------------------------------------------------
	// sampling geometry
	// ------------------------------------------------------------

	// marker samples delivered per clock127 cycle
	localparam int SAMPLES_PER_CYCLE = 4;

	// clock127 cycles in one decision frame
	localparam int CYCLES_PER_FRAME = 4;

	localparam int WINDOW_WIDTH = SAMPLES_PER_CYCLE * CYCLES_PER_FRAME;

	// earliest samples of the window that have to be quiet
	localparam int GUARD_HALF = 8;

	localparam int FRAME_PHASE_WIDTH = $clog2(CYCLES_PER_FRAME);

	// ------------------------------------------------------------
	// sample and phase types
	// ------------------------------------------------------------

	// bit 3 is the earliest sample of the cycle, bit 0 the latest
	typedef logic [SAMPLES_PER_CYCLE-1:0] sample_word_t;

	// bit 15 is the earliest sample of the frame, bit 0 the latest
	typedef logic [WINDOW_WIDTH-1:0] sample_window_t;

	// cycle index within a frame
	typedef logic [FRAME_PHASE_WIDTH-1:0] frame_phase_t;

	localparam frame_phase_t FIRST_PHASE = frame_phase_t'(0);
	localparam frame_phase_t LAST_PHASE = frame_phase_t'(CYCLES_PER_FRAME - 1);

endpackage
